// File: a_block_repeat.sv
// A block repeater that presents each accepted block A_REPEAT times
`timescale 1ns/100ps
`default_nettype none

module a_block_repeat
  import mxint_pkg::*;
#(
  parameter int A_REPEAT = DEPTH
) (
  input  wire logic clk,
  input  wire logic rst,
  mx_block_if.snk   in,
  mx_block_if.src   out
);

  localparam int CW = (A_REPEAT > 1) ? $clog2(A_REPEAT) : 1;

  rep_state_t state;
  logic [CW-1:0] rep_cnt;
  man_t man_q [BLOCK_N];
  exp_t exp_q;
  logic in_fire;
  logic out_fire;
  logic rep_last;

  assign out_fire = out.valid && out.ready;
  assign in_fire = in.valid && in.ready;
  assign rep_last = (rep_cnt == CW'(A_REPEAT - 1));

  // Refill on the final transfer so the stream has no bubble
  assign in.ready = (state == EMPTY) || (out_fire && rep_last);

  assign out.valid = (state == HOLD);
  assign out.man = man_q;
  assign out.exp = exp_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= EMPTY;
      rep_cnt <= '0;
    end else begin
      if (out_fire) begin
        rep_cnt <= rep_last ? '0 : rep_cnt + 1'b1;
      end
      if (in_fire) begin
        state <= HOLD;
      end else if (out_fire && rep_last) begin
        state <= EMPTY;
      end
    end
  end

  // Held block
  always_ff @(posedge clk) begin
    if (in_fire) begin
      man_q <= in.man;
      exp_q <= in.exp;
    end
  end

endmodule

`default_nettype wire

// File: accumulator_bank.sv
// Accumulator bank with one accumulator per C block column and round-robin read and write pointers
`timescale 1ns/100ps
`default_nettype none

module accumulator_bank
  import mxint_pkg::*;
#(
  parameter int NUM_ACC = DEPTH,
  parameter int ACC_DEPTH = DEPTH
) (
  input  wire logic clk,
  input  wire logic rst,
  mx_block_if.snk   in,
  mx_block_if.src   out
);

  localparam int PW = (NUM_ACC > 1) ? $clog2(NUM_ACC) : 1;

  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [NUM_ACC-1:0] in_rdy;
  logic [NUM_ACC-1:0] out_vld;
  acc_man_t res_man [NUM_ACC][BLOCK_N];
  prod_exp_t res_exp [NUM_ACC];

  mx_block_if #(.MAN_WIDTH(PROD_W), .EXP_WIDTH(PROD_EXP_W)) acc_in [NUM_ACC] ();
  mx_block_if #(.MAN_WIDTH(ACC_W), .EXP_WIDTH(PROD_EXP_W)) acc_out [NUM_ACC] ();

  for (genvar g = 0; g < NUM_ACC; g++) begin : gen_acc
    // Product data fans out and valid goes only to the selected column
    assign acc_in[g].man = in.man;
    assign acc_in[g].exp = in.exp;
    assign acc_in[g].valid = in.valid && (wr_ptr == g);
    assign in_rdy[g] = acc_in[g].ready;

    assign acc_out[g].ready = out.ready && (rd_ptr == g);
    assign out_vld[g] = acc_out[g].valid;
    assign res_man[g] = acc_out[g].man;
    assign res_exp[g] = acc_out[g].exp;

    block_accumulator #(
      .ACC_DEPTH(ACC_DEPTH)
    ) u_acc (
      .clk(clk),
      .rst(rst),
      .in (acc_in[g]),
      .out(acc_out[g])
    );
  end

  assign in.ready = in_rdy[wr_ptr];
  assign out.valid = out_vld[rd_ptr];
  assign out.man = res_man[rd_ptr];
  assign out.exp = res_exp[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (in.valid && in.ready) begin
        wr_ptr <= (wr_ptr == PW'(NUM_ACC - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (out.valid && out.ready) begin
        rd_ptr <= (rd_ptr == PW'(NUM_ACC - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // Sums finish in column order so the read pointer sits on the oldest one
  a_ptr_range: assert property (@(posedge clk) disable iff (rst)
    (|out_vld) |-> out_vld[rd_ptr]);

endmodule

`default_nettype wire

// File: b_block_buffer.sv
// B block buffer that stores a whole B matrix and replays it B_REPLAY times
`timescale 1ns/100ps
`default_nettype none

module b_block_buffer
  import mxint_pkg::*;
#(
  parameter int B_BLOCKS = DEPTH * DEPTH,
  parameter int B_REPLAY = DEPTH
) (
  input  wire logic clk,
  input  wire logic rst,
  mx_block_if.snk   in,
  mx_block_if.src   out
);

  localparam int AW = (B_BLOCKS > 1) ? $clog2(B_BLOCKS) : 1;
  localparam int RW = (B_REPLAY > 1) ? $clog2(B_REPLAY) : 1;

  buf_state_t state;
  logic [AW-1:0] wr_addr;
  logic [AW-1:0] rd_addr;
  logic [RW-1:0] rep_cnt;
  logic in_fire;
  logic out_fire;
  logic wr_last;
  logic rd_last;
  logic rep_last;

  // Block storage with one entry per B block in arrival order
  man_t mem_man [B_BLOCKS][BLOCK_N];
  exp_t mem_exp [B_BLOCKS];

  assign in.ready = (state == LOAD);
  assign out.valid = (state == REPLAY);
  assign out.man = mem_man[rd_addr];
  assign out.exp = mem_exp[rd_addr];

  assign in_fire = in.valid && in.ready;
  assign out_fire = out.valid && out.ready;
  assign wr_last = (wr_addr == AW'(B_BLOCKS - 1));
  assign rd_last = (rd_addr == AW'(B_BLOCKS - 1));
  assign rep_last = (rep_cnt == RW'(B_REPLAY - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= LOAD;
      wr_addr <= '0;
      rd_addr <= '0;
      rep_cnt <= '0;
    end else begin
      case (state)
        LOAD: begin
          if (in_fire) begin
            wr_addr <= wr_last ? '0 : wr_addr + 1'b1;
            if (wr_last) begin
              state <= REPLAY;
            end
          end
        end
        REPLAY: begin
          if (out_fire) begin
            rd_addr <= rd_last ? '0 : rd_addr + 1'b1;
            // End of one full pass over B
            if (rd_last) begin
              rep_cnt <= rep_last ? '0 : rep_cnt + 1'b1;
              if (rep_last) begin
                state <= LOAD;
              end
            end
          end
        end
        default: state <= LOAD;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      mem_man[wr_addr] <= in.man;
      mem_exp[wr_addr] <= in.exp;
    end
  end

  // Write address wraps to zero exactly when the last B block is stored
  a_wr_addr_range: assert property (@(posedge clk) disable iff (rst)
    (state == REPLAY) |-> (wr_addr == '0));

endmodule

`default_nettype wire

// File: block_accumulator.sv
// Block accumulator that sums ACC_DEPTH block products with exponent alignment
`timescale 1ns/100ps
`default_nettype none

module block_accumulator
  import mxint_pkg::*;
#(
  parameter int ACC_DEPTH = DEPTH
) (
  input  wire logic clk,
  input  wire logic rst,
  mx_block_if.snk   in,
  mx_block_if.src   out
);

  localparam int CW = (ACC_DEPTH > 1) ? $clog2(ACC_DEPTH) : 1;

  logic [CW-1:0] cnt;
  logic valid_q;
  acc_man_t [BLOCK_N-1:0] acc_q;
  acc_man_t [BLOCK_N-1:0] acc_d;
  prod_exp_t exp_q;
  prod_exp_t exp_d;
  logic signed [PROD_EXP_W:0] ediff;
  logic [PROD_EXP_W:0] shamt;
  logic in_larger;
  logic in_fire;
  logic first;
  logic last;

  // No new products while a finished sum waits
  assign in.ready = !valid_q;
  assign in_fire = in.valid && in.ready;
  assign first = (cnt == '0);
  assign last = (cnt == CW'(ACC_DEPTH - 1));

  // Exponent difference, one bit wider than either exponent
  assign ediff = (PROD_EXP_W+1)'(in.exp) - (PROD_EXP_W+1)'(exp_q);
  assign in_larger = (ediff > 0);
  assign shamt = in_larger ? ediff : -ediff;

  always_comb begin
    if (first) begin
      exp_d = in.exp;
    end else begin
      exp_d = in_larger ? prod_exp_t'(in.exp) : exp_q;
    end
    for (int i = 0; i < BLOCK_N; i++) begin
      if (first) begin
        acc_d[i] = acc_man_t'(in.man[i]);
      end else if (in_larger) begin
        // running sum is the smaller one, shift it down
        acc_d[i] = ($signed(acc_q[i]) >>> shamt) + acc_man_t'(in.man[i]);
      end else begin
        acc_d[i] = $signed(acc_q[i]) + (acc_man_t'(in.man[i]) >>> shamt);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
      valid_q <= 1'b0;
    end else if (in_fire) begin
      cnt <= last ? '0 : cnt + 1'b1;
      if (last) begin
        valid_q <= 1'b1;
      end
    end else if (out.valid && out.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      acc_q <= acc_d;
      exp_q <= exp_d;
    end
  end

  for (genvar i = 0; i < BLOCK_N; i++) begin : gen_out
    assign out.man[i] = acc_q[i];
  end
  assign out.exp = exp_q;
  assign out.valid = valid_q;

endmodule

`default_nettype wire

// File: block_matmul.sv
// Block multiplier joining A and B streams into a registered 2x2 product with exponent sum
`timescale 1ns/100ps
`default_nettype none

module block_matmul
  import mxint_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst,
  mx_block_if.snk   a,
  mx_block_if.snk   b,
  mx_block_if.src   out
);

  localparam int SIDE = 2;

  prod_man_t [BLOCK_N-1:0] dot;
  prod_man_t [BLOCK_N-1:0] man_q;
  prod_exp_t exp_q;
  logic valid_q;
  logic take_ok;
  logic join_fire;

  // Output register free or being drained this cycle
  assign take_ok = !valid_q || out.ready;
  assign join_fire = a.valid && b.valid && take_ok;

  // Both sides are consumed together
  assign a.ready = join_fire;
  assign b.ready = join_fire;

  // C[r][c] = sum over m of A[r][m] * B[m][c]
  always_comb begin
    for (int r = 0; r < SIDE; r++) begin
      for (int c = 0; c < SIDE; c++) begin
        dot[r*SIDE+c] = '0;
        for (int m = 0; m < SIDE; m++) begin
          dot[r*SIDE+c] = dot[r*SIDE+c]
                        + prod_man_t'(a.man[r*SIDE+m]) * prod_man_t'(b.man[m*SIDE+c]);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (join_fire) begin
      valid_q <= 1'b1;
    end else if (out.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (join_fire) begin
      man_q <= dot;
      exp_q <= prod_exp_t'(a.exp) + prod_exp_t'(b.exp);
    end
  end

  for (genvar i = 0; i < BLOCK_N; i++) begin : gen_out
    assign out.man[i] = man_q[i];
  end
  assign out.exp = exp_q;
  assign out.valid = valid_q;

  // Product held steady while the accumulator bank stalls
  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    (out.valid && !out.ready) |=> ($stable(man_q) && $stable(out.exp)));

endmodule

`default_nettype wire

// File: mx_block_if.sv
// Block stream interface with mantissas, shared exponent, valid/ready and modports
`timescale 1ns/100ps
`default_nettype none

interface mx_block_if
  import mxint_pkg::*;
#(
  parameter int MAN_WIDTH = MAN_W,
  parameter int EXP_WIDTH = EXP_W
);

  // One 2x2 block, row-major
  logic signed [MAN_WIDTH-1:0] man [BLOCK_N];
  logic signed [EXP_WIDTH-1:0] exp;
  logic valid;
  logic ready;

  // Producer side
  modport src (output man, exp, valid, input ready);

  // Consumer side
  modport snk (input man, exp, valid, output ready);

endinterface

`default_nettype wire

// File: mxint_matmul.sv
// MXINT 4x4 matrix multiplier top level built from 2x2 block pipeline stages
`timescale 1ns/100ps
`default_nettype none

module mxint_matmul
  import mxint_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  // Matrix A blocks, row-major
  input  wire man_t      a_man [BLOCK_N],
  input  wire exp_t      a_exp,
  input  wire logic      a_valid,
  output logic           a_ready,
  // Matrix B blocks, row-major
  input  wire man_t      b_man [BLOCK_N],
  input  wire exp_t      b_exp,
  input  wire logic      b_valid,
  output logic           b_ready,
  // Matrix C blocks, unrounded
  output acc_man_t       out_man [BLOCK_N],
  output prod_exp_t      out_exp,
  output logic           out_valid,
  input  wire logic      out_ready
);

  localparam int A_REPEAT = DEPTH;
  localparam int B_BLOCKS = DEPTH * DEPTH;
  localparam int B_REPLAY = DEPTH;
  localparam int ACC_DEPTH = DEPTH;
  localparam int NUM_ACC = DEPTH;

  // Fixed shape: 4x4 total, 2x2 compute
  if (BLOCK_N != 4 || DEPTH != 2) begin : gen_bad_shape
    $fatal(1, "mxint_matmul supports only 4x4 matrices in 2x2 blocks");
  end
  if (PROD_W < 2 * MAN_W + 1 || PROD_EXP_W < EXP_W + 1 || ACC_W <= PROD_W) begin : gen_bad_width
    $fatal(1, "mxint_matmul widths too narrow for the block product");
  end

  mx_block_if #(.MAN_WIDTH(MAN_W), .EXP_WIDTH(EXP_W)) a_in ();
  mx_block_if #(.MAN_WIDTH(MAN_W), .EXP_WIDTH(EXP_W)) b_in ();
  mx_block_if #(.MAN_WIDTH(MAN_W), .EXP_WIDTH(EXP_W)) a_rep ();
  mx_block_if #(.MAN_WIDTH(MAN_W), .EXP_WIDTH(EXP_W)) b_rep ();
  mx_block_if #(.MAN_WIDTH(PROD_W), .EXP_WIDTH(PROD_EXP_W)) prod ();
  mx_block_if #(.MAN_WIDTH(ACC_W), .EXP_WIDTH(PROD_EXP_W)) c_out ();

  assign a_in.man = a_man;
  assign a_in.exp = a_exp;
  assign a_in.valid = a_valid;
  assign a_ready = a_in.ready;

  assign b_in.man = b_man;
  assign b_in.exp = b_exp;
  assign b_in.valid = b_valid;
  assign b_ready = b_in.ready;

  assign out_man = c_out.man;
  assign out_exp = c_out.exp;
  assign out_valid = c_out.valid;
  assign c_out.ready = out_ready;

  // Each A block once per C block column
  a_block_repeat #(
    .A_REPEAT(A_REPEAT)
  ) u_a_repeat (
    .clk(clk),
    .rst(rst),
    .in (a_in),
    .out(a_rep)
  );

  // Whole of B once per C block row
  b_block_buffer #(
    .B_BLOCKS(B_BLOCKS),
    .B_REPLAY(B_REPLAY)
  ) u_b_buffer (
    .clk(clk),
    .rst(rst),
    .in (b_in),
    .out(b_rep)
  );

  block_matmul u_block_matmul (
    .clk(clk),
    .rst(rst),
    .a  (a_rep),
    .b  (b_rep),
    .out(prod)
  );

  accumulator_bank #(
    .NUM_ACC  (NUM_ACC),
    .ACC_DEPTH(ACC_DEPTH)
  ) u_acc_bank (
    .clk(clk),
    .rst(rst),
    .in (prod),
    .out(c_out)
  );

endmodule

`default_nettype wire

// File: mxint_pkg.sv
// Shared widths, block sizes, value types and FSM state enums for the MXINT matmul
`default_nettype none

package mxint_pkg;

  // Input block format
  localparam int MAN_W = 8;
  localparam int EXP_W = 4;

  // 2x2 blocks, 2 blocks per matrix dimension
  localparam int BLOCK_N = 4;
  localparam int DEPTH = 2;

  // Block product is two 8x8 products summed
  localparam int PROD_W = 17;
  localparam int PROD_EXP_W = 5;

  // Headroom for DEPTH aligned products
  localparam int ACC_W = 20;

  typedef logic signed [MAN_W-1:0] man_t;
  typedef logic signed [EXP_W-1:0] exp_t;
  typedef logic signed [PROD_W-1:0] prod_man_t;
  typedef logic signed [PROD_EXP_W-1:0] prod_exp_t;
  typedef logic signed [ACC_W-1:0] acc_man_t;

  // B buffer: fill, then replay once per A block row
  typedef enum logic {
    LOAD,
    REPLAY
  } buf_state_t;

  // A repeat: waiting for a block, or presenting the held one
  typedef enum logic {
    EMPTY,
    HOLD
  } rep_state_t;

endpackage

`default_nettype wire

// File: mxint_stim.txt
# T bp: new test, bp 1 toggles out_ready randomly. Then two A, two B and two C lines.
# A/B/C: exp m0 m1 m2 m3 exp m0 m1 m2 m3 (two 2x2 blocks, row-major, in stream order)
T 0
A 0 1 2 -5 6 0 3 4 -7 8
A 0 9 -10 13 14 0 11 -12 -15 16
B 0 1 0 0 1 0 0 0 0 0
B 0 0 0 0 0 0 1 0 0 1
C 0 1 2 -5 6 0 3 4 -7 8
C 0 9 -10 13 14 0 11 -12 -15 16
T 0
A 0 -128 127 2 -3 0 0 1 -128 -128
A 0 0 0 10 0 0 5 -1 0 -2
B 0 -128 1 1 -1 0 0 2 3 0
B 0 -128 0 4 -128 0 1 -1 0 7
C 0 16515 -383 15613 16389 0 381 -249 -137 -764
C 0 -644 128 -1288 266 0 5 -12 0 6
T 0
A 2 10 -20 30 7 -1 -50 60 100 -3
A 0 1 2 -3 -4 3 25 -25 12 -100
B 1 3 -1 2 5 -2 -7 1 4 9
B 0 8 0 -2 11 4 6 -5 3 2
C 3 -43 -69 154 2 3 -139 348 568 -495
C 3 251 -273 291 -1105 7 75 -175 -228 -261
T 1
A 2 10 -20 30 7 -1 -50 60 100 -3
A 0 1 2 -3 -4 3 25 -25 12 -100
B 1 3 -1 2 5 -2 -7 1 4 9
B 0 8 0 -2 11 4 6 -5 3 2
C 3 -43 -69 154 2 3 -139 348 568 -495
C 3 251 -273 291 -1105 7 75 -175 -228 -261

// File: src.f
mxint_pkg.sv
mx_block_if.sv
a_block_repeat.sv
b_block_buffer.sv
block_matmul.sv
block_accumulator.sv
accumulator_bank.sv
mxint_matmul.sv
tb_mxint_matmul.sv

// File: tb_mxint_matmul.sv
// Testbench for the MXINT matmul with file-driven blocks, expected C blocks and reporting
`timescale 1ns/100ps
`default_nettype none

module tb_mxint_matmul
  import mxint_pkg::*;
();

  localparam int NBLK = DEPTH * DEPTH;
  localparam int TIMEOUT = 500;
  localparam int QUIET = 8;

  logic clk;
  logic rst;
  man_t a_man [BLOCK_N];
  exp_t a_exp;
  logic a_valid;
  logic a_ready;
  man_t b_man [BLOCK_N];
  exp_t b_exp;
  logic b_valid;
  logic b_ready;
  acc_man_t out_man [BLOCK_N];
  prod_exp_t out_exp;
  logic out_valid;
  logic out_ready;

  // Blocks of one test with first index 0 for A, 1 for B and 2 for expected C
  int stim_e [3][NBLK];
  int stim_m [3][NBLK][BLOCK_N];

  int fd;
  string line;
  int seed = 5079;
  int rnd;
  logic bp_on;
  logic bp_next;
  logic abort_run;
  logic more;
  int test_no;
  int test_errs;
  int n_pass;
  int n_fail;

  mxint_matmul u_mxint_matmul (
    .clk      (clk),
    .rst      (rst),
    .a_man    (a_man),
    .a_exp    (a_exp),
    .a_valid  (a_valid),
    .a_ready  (a_ready),
    .b_man    (b_man),
    .b_exp    (b_exp),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .out_man  (out_man),
    .out_exp  (out_exp),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  always #5 clk = ~clk;

  // Random stalls on the C stream when the test asks for them
  always @(posedge clk) begin
    rnd = $random(seed);
    out_ready <= bp_on ? rnd[0] : 1'b1;
  end

  // Next record line with comments and blank lines skipped
  task next_line(output logic got);
    int rc;
    got = 1'b0;
    while (!got && !$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      if (rc > 0 && line.len() > 0) begin
        got = (line[0] == "T" || line[0] == "A" || line[0] == "B" || line[0] == "C");
      end
    end
  endtask

  // One line holds two blocks of an exponent and four mantissas each
  task parse_pair(input int kind, input int first, output logic ok);
    byte tag;
    byte want;
    int v [10];
    int rc;
    logic got;
    want = (kind == 0) ? "A" : (kind == 1) ? "B" : "C";
    tag = 8'h00;
    rc = 0;
    next_line(got);
    if (got) begin
      rc = $sscanf(line, "%c %d %d %d %d %d %d %d %d %d %d", tag,
                   v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
    end
    ok = (rc == 11) && (tag == want);
    for (int b = 0; b < 2; b++) begin
      stim_e[kind][first+b] = v[b*5];
      for (int e = 0; e < BLOCK_N; e++) begin
        stim_m[kind][first+b][e] = v[b*5+1+e];
      end
    end
  endtask

  task load_test(output logic got);
    int rc;
    int flag;
    byte tag;
    logic ok;
    next_line(got);
    if (got) begin
      rc = $sscanf(line, "%c %d", tag, flag);
      ok = (rc == 2) && (tag == "T");
      for (int k = 0; k < 3; k++) begin
        for (int h = 0; h < 2; h++) begin
          if (ok) begin
            parse_pair(k, 2 * h, ok);
          end
        end
      end
      if (!ok) begin
        $display("Stimulus file is malformed after test %0d", test_no);
        abort_run = 1'b1;
        got = 1'b0;
      end
      bp_next = (flag != 0);
    end
  endtask

  // Feed all four A or B blocks in stream order
  task automatic send_blocks(input int kind);
    int cnt;
    logic rdy;
    for (int n = 0; n < NBLK && !abort_run; n++) begin
      for (int e = 0; e < BLOCK_N; e++) begin
        if (kind == 0) begin
          a_man[e] <= man_t'(stim_m[0][n][e]);
        end else begin
          b_man[e] <= man_t'(stim_m[1][n][e]);
        end
      end
      if (kind == 0) begin
        a_exp <= exp_t'(stim_e[0][n]);
        a_valid <= 1'b1;
      end else begin
        b_exp <= exp_t'(stim_e[1][n]);
        b_valid <= 1'b1;
      end
      cnt = 0;
      rdy = 1'b0;
      while (!rdy && cnt < TIMEOUT) begin
        @(negedge clk);
        cnt++;
        rdy = (kind == 0) ? a_ready : b_ready;
      end
      if (!rdy) begin
        $display("DUT stalled: %s input not ready for %0d cycles in test %0d",
                 (kind == 0) ? "A" : "B", TIMEOUT, test_no);
        abort_run = 1'b1;
      end
      @(posedge clk);
    end
    if (kind == 0) begin
      a_valid <= 1'b0;
    end else begin
      b_valid <= 1'b0;
    end
  endtask

  // Sample each C block at the negedge where its handshake is settled
  task automatic collect_blocks();
    int cnt;
    logic same;
    for (int n = 0; n < NBLK && !abort_run; n++) begin
      cnt = 0;
      do begin
        @(negedge clk);
        cnt++;
      end while (!(out_valid && out_ready) && cnt < TIMEOUT);
      if (!(out_valid && out_ready)) begin
        $display("DUT stalled: C block %0d did not arrive within %0d cycles in test %0d",
                 n, TIMEOUT, test_no);
        abort_run = 1'b1;
      end else begin
        same = (int'(out_exp) == stim_e[2][n]);
        for (int e = 0; e < BLOCK_N; e++) begin
          same = same && (int'(out_man[e]) == stim_m[2][n][e]);
        end
        assert (same) else begin
          $display("MISMATCH at %0t: test %0d C block %0d got exp %0d man %0d %0d %0d %0d",
                   $time, test_no, n, out_exp, out_man[0], out_man[1], out_man[2],
                   out_man[3]);
          $display("  expected exp %0d man %0d %0d %0d %0d", stim_e[2][n],
                   stim_m[2][n][0], stim_m[2][n][1], stim_m[2][n][2], stim_m[2][n][3]);
          test_errs++;
        end
      end
    end
    // No further C block once all four have left
    if (!abort_run) begin
      for (int q = 0; q < QUIET; q++) begin
        @(negedge clk);
        assert (!out_valid) else begin
          $display("Extra C block offered at %0t after the last one in test %0d",
                   $time, test_no);
          test_errs++;
        end
      end
    end
  endtask

  task run_test();
    test_errs = 0;
    @(negedge clk);
    bp_on = bp_next;
    @(posedge clk);
    fork
      send_blocks(0);
      send_blocks(1);
      collect_blocks();
    join
    if (test_errs == 0 && !abort_run) begin
      n_pass++;
      $display("test %0d passed, back-pressure %0d", test_no, bp_on);
    end else begin
      n_fail++;
      $display("test %0d failed, %0d mismatches", test_no, test_errs);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    a_valid = 1'b0;
    b_valid = 1'b0;
    a_exp = '0;
    b_exp = '0;
    for (int e = 0; e < BLOCK_N; e++) begin
      a_man[e] = '0;
      b_man[e] = '0;
    end
    out_ready = 1'b0;
    bp_on = 1'b0;
    bp_next = 1'b0;
    abort_run = 1'b0;
    test_no = 0;
    n_pass = 0;
    n_fail = 0;
    fd = $fopen("mxint_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file mxint_stim.txt");
      abort_run = 1'b1;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    // Tests run back to back with no reset between them
    more = !abort_run;
    while (more) begin
      load_test(more);
      if (more) begin
        test_no++;
        run_test();
        more = !abort_run;
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0 && n_pass > 0 && !abort_run) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
